// ==== Makefile ====
# Verilator build and run of the bounding-box testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module bbox_tb -f list.f -o bbox_sim
	./obj_dir/bbox_sim | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/bbox_compute.sv ====
// Bounding box min/max, multisample grid flooring, screen clamp and reject
`timescale 1ns/10ps

module bbox_compute (
    input  raster_pkg::tri_stage_t in_stage,
    input  raster_pkg::coord_t     screen_x,
    input  raster_pkg::coord_t     screen_y,
    input  raster_pkg::sample_t    sample,
    output raster_pkg::box_stage_t out_stage
);

    raster_pkg::vertex_t raw_ll;
    raster_pkg::vertex_t raw_ur;
    raster_pkg::vertex_t fl_ll;
    raster_pkg::vertex_t fl_ur;
    raster_pkg::vertex_t cl_ll;
    raster_pkg::vertex_t cl_ur;
    logic [raster_pkg::radix-1:0] frac_mask;
    raster_pkg::coord_t grid_mask;
    logic reject;

    // Signed min and max over the vertices
    always_comb begin
        raw_ll = in_stage.tri_data[0];
        raw_ur = in_stage.tri_data[0];
        for (int i = 1; i < raster_pkg::verts; i++) begin
            if (in_stage.tri_data[i].x < raw_ll.x) begin
                raw_ll.x = in_stage.tri_data[i].x;
            end
            if (in_stage.tri_data[i].y < raw_ll.y) begin
                raw_ll.y = in_stage.tri_data[i].y;
            end
            if (in_stage.tri_data[i].x > raw_ur.x) begin
                raw_ur.x = in_stage.tri_data[i].x;
            end
            if (in_stage.tri_data[i].y > raw_ur.y) begin
                raw_ur.y = in_stage.tri_data[i].y;
            end
        end
    end

    // Keep the top 0 to 3 fraction bits, one more per sample step
    always_comb begin
        case (sample)
            raster_pkg::sample_4x:  frac_mask = {1'b1, {(raster_pkg::radix-1){1'b0}}};
            raster_pkg::sample_16x: frac_mask = {2'b11, {(raster_pkg::radix-2){1'b0}}};
            raster_pkg::sample_64x: frac_mask = {3'b111, {(raster_pkg::radix-3){1'b0}}};
            default:                frac_mask = '0;
        endcase
    end

    assign grid_mask = {{(raster_pkg::sig_fig-raster_pkg::radix){1'b1}}, frac_mask};

    // Clearing low bits of a two's complement value floors it
    assign fl_ll.x = raw_ll.x & grid_mask;
    assign fl_ll.y = raw_ll.y & grid_mask;
    assign fl_ur.x = raw_ur.x & grid_mask;
    assign fl_ur.y = raw_ur.y & grid_mask;

    // Clamp lower-left to origin, upper-right to screen edge
    always_comb begin
        cl_ll.x = (fl_ll.x < 0) ? '0 : fl_ll.x;
        cl_ll.y = (fl_ll.y < 0) ? '0 : fl_ll.y;
        cl_ur.x = (fl_ur.x >= screen_x) ? screen_x : fl_ur.x;
        cl_ur.y = (fl_ur.y >= screen_y) ? screen_y : fl_ur.y;
    end

    // Wholly off screen, tested on floored but unclamped corners
    assign reject = (fl_ur.x < 0) || (fl_ur.y < 0)
        || (fl_ll.x >= screen_x) || (fl_ll.y >= screen_y);

    assign out_stage.valid = in_stage.valid && !reject;
    assign out_stage.box.ll = cl_ll;
    assign out_stage.box.ur = cl_ur;

endmodule

// ==== design/bbox_top.sv ====
// Bounding-box stage top level with APB configuration
// Input register, compute stage and two-deep output pipelines
`timescale 1ns/10ps

module bbox_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              halt,
    // APB configuration port
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [raster_pkg::apb_addr_w-1:0] paddr,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,
    // Triangle in
    input  raster_pkg::tri_t                  tri_in,
    input  logic                              tri_valid,
    // Box and triangle out
    output raster_pkg::box_t                  box_out,
    output logic                              box_valid,
    output raster_pkg::tri_t                  tri_out
);

    raster_pkg::coord_t screen_x;
    raster_pkg::coord_t screen_y;
    raster_pkg::sample_t sample;
    raster_pkg::tri_stage_t in_d;
    raster_pkg::tri_stage_t in_q;
    raster_pkg::box_stage_t box_d;
    raster_pkg::box_stage_t box_q;

    raster_config_apb u_config (
        .clk      (clk),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .screen_x (screen_x),
        .screen_y (screen_y),
        .sample   (sample)
    );

    assign in_d.valid = tri_valid;
    assign in_d.tri_data = tri_in;

    // First cycle of latency
    stall_pipe #(
        .payload_t (raster_pkg::tri_stage_t),
        .DEPTH     (1)
    ) u_in_stage (
        .clk   (clk),
        .reset (reset),
        .halt  (halt),
        .d     (in_d),
        .q     (in_q)
    );

    bbox_compute u_compute (
        .in_stage  (in_q),
        .screen_x  (screen_x),
        .screen_y  (screen_y),
        .sample    (sample),
        .out_stage (box_d)
    );

    // Triangle travels alongside its box
    stall_pipe #(
        .payload_t (raster_pkg::tri_t),
        .DEPTH     (raster_pkg::out_depth)
    ) u_tri_pipe (
        .clk   (clk),
        .reset (reset),
        .halt  (halt),
        .d     (in_q.tri_data),
        .q     (tri_out)
    );

    stall_pipe #(
        .payload_t (raster_pkg::box_stage_t),
        .DEPTH     (raster_pkg::out_depth)
    ) u_box_pipe (
        .clk   (clk),
        .reset (reset),
        .halt  (halt),
        .d     (box_d),
        .q     (box_q)
    );

    assign box_out = box_q.box;
    assign box_valid = box_q.valid;

endmodule

// ==== design/raster_config_apb.sv ====
// APB slave with the screen size and multisample configuration registers
`timescale 1ns/10ps

module raster_config_apb (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [raster_pkg::apb_addr_w-1:0] paddr,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,
    output raster_pkg::coord_t                screen_x,
    output raster_pkg::coord_t                screen_y,
    output raster_pkg::sample_t               sample
);

    logic setup;
    logic access;
    logic hit_x;
    logic hit_y;
    logic hit_sample;
    logic code_ok;
    logic xfer_err;
    logic [31:0] rd_value;

    // No wait states
    assign pready = 1'b1;

    // Setup phase is one cycle ahead of the access phase
    assign setup = psel && !penable;
    assign access = psel && penable;

    assign hit_x = (paddr == raster_pkg::addr_screen_x);
    assign hit_y = (paddr == raster_pkg::addr_screen_y);
    assign hit_sample = (paddr == raster_pkg::addr_sample);

    // Exactly one bit set in the low nibble, nothing above it
    assign code_ok = (pwdata[31:4] == 28'b0) && (pwdata[3:0] != 4'b0)
        && ((pwdata[3:0] & (pwdata[3:0] - 4'd1)) == 4'b0);

    // Unknown address, or a bad sample code on a write
    assign xfer_err = !(hit_x || hit_y || hit_sample)
        || (pwrite && hit_sample && !code_ok);

    // Read mux, zero-extended
    always_comb begin
        rd_value = 32'b0;
        if (hit_x) begin
            rd_value = {{(32-raster_pkg::sig_fig){1'b0}}, screen_x};
        end else if (hit_y) begin
            rd_value = {{(32-raster_pkg::sig_fig){1'b0}}, screen_y};
        end else if (hit_sample) begin
            rd_value = {28'b0, sample};
        end
    end

    // Response is captured on the setup edge so it is stable during access
    always_ff @(posedge clk) begin
        if (reset) begin
            prdata <= 32'b0;
            pslverr <= 1'b0;
        end else begin
            prdata <= (setup && !pwrite) ? rd_value : 32'b0;
            pslverr <= setup ? xfer_err : 1'b0;
        end
    end

    // Registers update at the edge that ends the access phase
    always_ff @(posedge clk) begin
        if (reset) begin
            screen_x <= '0;
            screen_y <= '0;
            sample <= raster_pkg::sample_1x;
        end else if (access && pwrite) begin
            if (hit_x) begin
                screen_x <= pwdata[raster_pkg::sig_fig-1:0];
            end
            if (hit_y) begin
                screen_y <= pwdata[raster_pkg::sig_fig-1:0];
            end
            // Bad codes leave the old value in place
            if (hit_sample && code_ok) begin
                sample <= pwdata[3:0];
            end
        end
    end

endmodule

// ==== design/raster_pkg.sv ====
// Shared fixed-point widths, APB register map and sample codes
// Payload types for the bounding-box pipeline stages
package raster_pkg;

    // Fixed-point coordinate format
    localparam int sig_fig = 24;
    localparam int radix = 10;
    localparam int verts = 3;

    // Output pipeline depth after the compute stage
    localparam int out_depth = 2;

    // APB register map, byte offsets
    localparam int apb_addr_w = 4;
    localparam logic [apb_addr_w-1:0] addr_screen_x = 4'h0;
    localparam logic [apb_addr_w-1:0] addr_screen_y = 4'h4;
    localparam logic [apb_addr_w-1:0] addr_sample = 4'h8;

    // One-hot multisample codes
    typedef logic [3:0] sample_t;
    localparam sample_t sample_1x = 4'b1000;
    localparam sample_t sample_4x = 4'b0100;
    localparam sample_t sample_16x = 4'b0010;
    localparam sample_t sample_64x = 4'b0001;

    // Signed coordinate, upper bits integer and low radix bits fraction
    typedef logic signed [sig_fig-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    typedef vertex_t [verts-1:0] tri_t;

    // Input stage payload
    typedef struct packed {
        logic valid;
        tri_t tri_data;
    } tri_stage_t;

    // Lower-left and upper-right corners
    typedef struct packed {
        vertex_t ll;
        vertex_t ur;
    } box_t;

    typedef struct packed {
        logic valid;
        box_t box;
    } box_stage_t;

endpackage

// ==== design/stall_pipe.sv ====
// Register chain of configurable depth and payload type, held by halt
`timescale 1ns/10ps

module stall_pipe #(
    parameter type payload_t = logic,
    parameter int DEPTH = 1
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     halt,
    input  payload_t d,
    output payload_t q
);

    payload_t stage [DEPTH];

    // Whole chain advances together, or freezes together
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else if (!halt) begin
            stage[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // Last register drives the output
    assign q = stage[DEPTH-1];

endmodule

// ==== dv/bbox_checker.sv ====
// Assertions on the box outputs and the sample configuration
`timescale 1ns/10ps

module bbox_checker (
    input logic                clk,
    input logic                reset,
    input logic                box_valid,
    input raster_pkg::box_t    box_out,
    input raster_pkg::coord_t  screen_x,
    input raster_pkg::coord_t  screen_y,
    input raster_pkg::sample_t sample
);

    // Corners in order on both axes
    assert property (@(posedge clk) disable iff (reset)
        box_valid |-> (box_out.ll.x <= box_out.ur.x) && (box_out.ll.y <= box_out.ur.y))
        else $error("box corners out of order");

    // Upper-right never beyond the screen
    assert property (@(posedge clk) disable iff (reset)
        box_valid |-> (box_out.ur.x <= screen_x) && (box_out.ur.y <= screen_y))
        else $error("box exceeds the screen");

    // Lower-left never negative
    assert property (@(posedge clk) disable iff (reset)
        box_valid |-> (box_out.ll.x >= 0) && (box_out.ll.y >= 0))
        else $error("box lower-left below origin");

    assert property (@(posedge clk) disable iff (reset) $onehot(sample))
        else $error("stored sample code is not one-hot");

endmodule

bind bbox_top bbox_checker u_checker (
    .clk       (clk),
    .reset     (reset),
    .box_valid (box_valid),
    .box_out   (box_out),
    .screen_x  (screen_x),
    .screen_y  (screen_y),
    .sample    (sample)
);

// ==== dv/bbox_tb.sv ====
// Directed testbench for the bounding-box stage
// Clock, APB and triangle drivers, reference model, compare tasks and timeout
`timescale 1ns/10ps

module bbox_tb;

    localparam int max_cycles = 5000;
    localparam int latency = 3;
    // 640 x 480 screen in fixed point
    localparam int scr_w = 640 * 1024;
    localparam int scr_h = 480 * 1024;

    logic clk;
    logic reset;
    logic halt;
    logic psel;
    logic penable;
    logic pwrite;
    logic [raster_pkg::apb_addr_w-1:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    raster_pkg::tri_t tri_in;
    logic tri_valid;
    raster_pkg::box_t box_out;
    logic box_valid;
    raster_pkg::tri_t tri_out;

    int errors;
    int checks;
    int cycles;
    logic checking;
    int unsigned seed;
    // Shadow of the configuration registers
    raster_pkg::coord_t cfg_sx;
    raster_pkg::coord_t cfg_sy;
    raster_pkg::sample_t cfg_sample;
    // Expected outputs, front entry is due now
    raster_pkg::box_stage_t exp_box_q[$];
    raster_pkg::tri_t exp_tri_q[$];

    bbox_top UUT (
        .clk       (clk),
        .reset     (reset),
        .halt      (halt),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .tri_in    (tri_in),
        .tri_valid (tri_valid),
        .box_out   (box_out),
        .box_valid (box_valid),
        .tri_out   (tri_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int unsigned lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed >> 8;
    endfunction

    function automatic raster_pkg::coord_t rand_coord(int lo, int unsigned span);
        return raster_pkg::coord_t'(lo + int'(lcg_next() % span));
    endfunction

    function automatic raster_pkg::tri_t rand_tri(int lo_x, int unsigned span_x,
                                                  int lo_y, int unsigned span_y);
        raster_pkg::tri_t t;
        for (int i = 0; i < raster_pkg::verts; i++) begin
            t[i].x = rand_coord(lo_x, span_x);
            t[i].y = rand_coord(lo_y, span_y);
        end
        return t;
    endfunction

    function automatic raster_pkg::tri_t make_tri(int x0, int y0, int x1, int y1,
                                                  int x2, int y2);
        raster_pkg::tri_t t;
        t[0].x = raster_pkg::coord_t'(x0);
        t[0].y = raster_pkg::coord_t'(y0);
        t[1].x = raster_pkg::coord_t'(x1);
        t[1].y = raster_pkg::coord_t'(y1);
        t[2].x = raster_pkg::coord_t'(x2);
        t[2].y = raster_pkg::coord_t'(y2);
        return t;
    endfunction

    // Floor toward minus infinity on the sample grid
    function automatic raster_pkg::coord_t floor_grid(raster_pkg::coord_t v,
                                                      raster_pkg::sample_t s);
        int sh;
        case (s)
            raster_pkg::sample_4x:  sh = raster_pkg::radix - 1;
            raster_pkg::sample_16x: sh = raster_pkg::radix - 2;
            raster_pkg::sample_64x: sh = raster_pkg::radix - 3;
            default:                sh = raster_pkg::radix;
        endcase
        return (v >>> sh) <<< sh;
    endfunction

    // Reference box: min/max, floor, reject on unclamped, then clamp
    function automatic raster_pkg::box_stage_t model_box(raster_pkg::tri_t t, logic v);
        raster_pkg::box_stage_t r;
        raster_pkg::coord_t lx;
        raster_pkg::coord_t ly;
        raster_pkg::coord_t ux;
        raster_pkg::coord_t uy;
        lx = t[0].x;
        ux = t[0].x;
        ly = t[0].y;
        uy = t[0].y;
        for (int i = 1; i < raster_pkg::verts; i++) begin
            lx = (t[i].x < lx) ? t[i].x : lx;
            ux = (t[i].x > ux) ? t[i].x : ux;
            ly = (t[i].y < ly) ? t[i].y : ly;
            uy = (t[i].y > uy) ? t[i].y : uy;
        end
        lx = floor_grid(lx, cfg_sample);
        ly = floor_grid(ly, cfg_sample);
        ux = floor_grid(ux, cfg_sample);
        uy = floor_grid(uy, cfg_sample);
        r.valid = v && !(ux < 0 || uy < 0 || lx >= cfg_sx || ly >= cfg_sy);
        r.box.ll.x = (lx < 0) ? '0 : lx;
        r.box.ll.y = (ly < 0) ? '0 : ly;
        r.box.ur.x = (ux >= cfg_sx) ? cfg_sx : ux;
        r.box.ur.y = (uy >= cfg_sy) ? cfg_sy : uy;
        return r;
    endfunction

    task automatic check_box(raster_pkg::box_t got, raster_pkg::box_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: box_out %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_valid(logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: box_valid %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_tri(raster_pkg::tri_t got, raster_pkg::tri_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: tri_out %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_apb(logic [31:0] got_data, logic [31:0] exp_data,
                             logic got_err, logic exp_err);
        checks++;
        if (got_data !== exp_data || got_err !== exp_err) begin
            errors++;
            $display("** Error at %0t: prdata %h pslverr %b, expected %h %b",
                     $time, got_data, got_err, exp_data, exp_err);
        end
    endtask

    // No wait states, so ready is high in every access phase
    task automatic check_ready(logic got);
        checks++;
        if (got !== 1'b1) begin
            errors++;
            $display("** Error at %0t: pready %b, expected 1", $time, got);
        end
    endtask

    // Setup phase, then access phase, response sampled during access
    task automatic apb_xfer(input logic wr, input logic [raster_pkg::apb_addr_w-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        rdata = prdata;
        err = pslverr;
        check_ready(pready);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(logic [raster_pkg::apb_addr_w-1:0] addr, logic [31:0] data,
                             logic exp_err);
        logic [31:0] rdata;
        logic err;
        apb_xfer(1'b1, addr, data, rdata, err);
        // Read data means nothing on a write, only the error is compared
        check_apb(32'h0, 32'h0, err, exp_err);
        if (!exp_err) begin
            if (addr == raster_pkg::addr_screen_x) begin
                cfg_sx = data[raster_pkg::sig_fig-1:0];
            end else if (addr == raster_pkg::addr_screen_y) begin
                cfg_sy = data[raster_pkg::sig_fig-1:0];
            end else begin
                cfg_sample = data[3:0];
            end
        end
    endtask

    task automatic apb_read(logic [raster_pkg::apb_addr_w-1:0] addr, logic [31:0] exp_data,
                            logic exp_err);
        logic [31:0] rdata;
        logic err;
        apb_xfer(1'b0, addr, 32'h0, rdata, err);
        check_apb(rdata, exp_data, err, exp_err);
    endtask

    task automatic drive_tri(raster_pkg::tri_t t, logic v);
        @(negedge clk);
        tri_in = t;
        tri_valid = v;
    endtask

    // Empty the pipeline
    task automatic drive_idle(int n);
        repeat (n) drive_tri('0, 1'b0);
    endtask

    task automatic test_apb();
        apb_write(raster_pkg::addr_screen_x, 32'(scr_w), 1'b0);
        apb_write(raster_pkg::addr_screen_y, 32'(scr_h), 1'b0);
        apb_read(raster_pkg::addr_screen_x, 32'(scr_w), 1'b0);
        apb_read(raster_pkg::addr_screen_y, 32'(scr_h), 1'b0);
        // Two bits set is refused and the old code stays
        apb_write(raster_pkg::addr_sample, 32'h6, 1'b1);
        apb_read(raster_pkg::addr_sample, {28'b0, raster_pkg::sample_1x}, 1'b0);
        apb_write(raster_pkg::addr_sample, 32'h0, 1'b1);
        apb_read(4'hc, 32'h0, 1'b1);
        apb_write(4'hc, 32'h1234, 1'b1);
    endtask

    task automatic test_random_1x();
        repeat (20) drive_tri(rand_tri(0, scr_w, 0, scr_h), 1'b1);
        drive_idle(latency + 1);
    endtask

    task automatic test_grid();
        raster_pkg::sample_t codes [3];
        codes[0] = raster_pkg::sample_4x;
        codes[1] = raster_pkg::sample_16x;
        codes[2] = raster_pkg::sample_64x;
        foreach (codes[i]) begin
            apb_write(raster_pkg::addr_sample, {28'b0, codes[i]}, 1'b0);
            // All-ones, half and quarter fractions land on different grid points
            drive_tri(make_tri(10 * 1024 + 1023, 20 * 1024 + 513, 100 * 1024 + 257,
                               30 * 1024 + 767, 50 * 1024 + 100, 200 * 1024 + 1023), 1'b1);
            drive_tri(make_tri(5 * 1024 + 384, 7 * 1024 + 128, 9 * 1024 + 896,
                               8 * 1024 + 640, 6 * 1024 + 1, 9 * 1024 + 511), 1'b1);
            repeat (4) drive_tri(rand_tri(0, scr_w, 0, scr_h), 1'b1);
            drive_idle(latency + 1);
        end
        apb_write(raster_pkg::addr_sample, {28'b0, raster_pkg::sample_1x}, 1'b0);
    endtask

    task automatic test_clip();
        // Partly off screen on the left and the top
        drive_tri(make_tri(-5000, 100 * 1024, 300 * 1024, scr_h + 77, 700 * 1024, -300), 1'b1);
        drive_tri(make_tri(-9000, 100, -5000, 2000, -20000, 40000), 1'b1);
        drive_tri(make_tri(100, -9000, 2000, -5000, 40000, -20000), 1'b1);
        drive_tri(make_tri(scr_w, 100, scr_w + 5000, 2000, scr_w + 80, 40000), 1'b1);
        drive_tri(make_tri(100, scr_h + 10, 2000, scr_h, 40000, scr_h + 9000), 1'b1);
        drive_tri(rand_tri(0, scr_w, 0, scr_h), 1'b0);
        drive_idle(latency + 1);
    endtask

    // Freeze the pipeline while inputs keep changing
    task automatic hold_outputs(int n);
        raster_pkg::box_t held_box;
        raster_pkg::tri_t held_tri;
        logic held_valid;
        @(negedge clk);
        halt = 1'b1;
        tri_in = rand_tri(0, scr_w, 0, scr_h);
        tri_valid = 1'b1;
        held_box = box_out;
        held_tri = tri_out;
        held_valid = box_valid;
        repeat (n) begin
            @(negedge clk);
            tri_in = rand_tri(0, scr_w, 0, scr_h);
            check_valid(box_valid, held_valid);
            check_box(box_out, held_box);
            check_tri(tri_out, held_tri);
        end
        halt = 1'b0;
    endtask

    task automatic test_halt();
        for (int i = 0; i < 16; i++) begin
            if (i == 6 || i == 11) begin
                hold_outputs(5);
            end
            drive_tri(rand_tri(-2000, scr_w + 4000, -2000, scr_h + 4000), 1'b1);
        end
        drive_idle(latency + 1);
    endtask

    // Reference model advances on every halt-low edge
    always @(posedge clk) begin
        if (reset) begin
            exp_box_q.delete();
            exp_tri_q.delete();
            repeat (latency) begin
                exp_box_q.push_back('0);
                exp_tri_q.push_back('0);
            end
        end else if (!halt) begin
            exp_box_q.push_back(model_box(tri_in, tri_valid));
            exp_tri_q.push_back(tri_in);
            exp_box_q.delete(0);
            exp_tri_q.delete(0);
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            check_valid(box_valid, exp_box_q[0].valid);
            if (exp_box_q[0].valid) begin
                check_box(box_out, exp_box_q[0].box);
            end
            check_tri(tri_out, exp_tri_q[0]);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Run timed out after %0d cycles, %0d errors so far", cycles, errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        errors = 0;
        checks = 0;
        cycles = 0;
        checking = 1'b0;
        seed = 19678;
        reset = 1'b1;
        halt = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        tri_in = '0;
        tri_valid = 1'b0;
        cfg_sx = '0;
        cfg_sy = '0;
        cfg_sample = raster_pkg::sample_1x;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        checking = 1'b1;
        test_apb();
        test_random_1x();
        test_grid();
        test_clip();
        test_halt();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== list.f ====
design/raster_pkg.sv
design/raster_config_apb.sv
design/stall_pipe.sv
design/bbox_compute.sv
design/bbox_top.sv
dv/bbox_checker.sv
dv/bbox_tb.sv
